/* list.f */
logic/core_pkg.sv
logic/regfile.sv
logic/ifu.sv
logic/idu.sv
logic/exu.sv
logic/lsu.sv
logic/mem_arbiter.sv
logic/core_top.sv
sim/core_checker.sv
sim/core_monitor.sv
sim/core_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the RV32I core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module core_tb -Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vcore_tb +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Testbench failed" sim.log; then
  exit 1
fi
exit 0

/* sim/core_tb.sv */
`timescale 1ns/1ps

module core_tb import core_pkg::*; ();
  localparam logic [31:0] RESET_PC     = 32'h0;
  localparam int          NUM_REGS     = 16;
  localparam int          MEM_WORDS    = 1024;
  localparam int          CODE_WORDS   = 300;
  localparam int          HALT_TIMEOUT = 20000;
  localparam int          IDLE_CYCLES  = 50;
  localparam int          CLK_PERIOD   = 100;

  logic        clk;
  logic        rst;
  mem_req_t    mem_req;
  mem_rsp_t    mem_rsp;
  retire_t     retire;
  logic        halt;
  logic [31:0] mem [MEM_WORDS];
  int          seed;
  logic        busy;
  int          delay;
  int          cycles;
  int          tb_errors;
  int          mon_errors;
  int          retired;
  logic        model_halted;

  core_top #(.RESET_PC(RESET_PC), .NUM_REGS(NUM_REGS)) dut_i (
    .clk(clk), .rst(rst),
    .mem_req_o(mem_req), .mem_rsp_i(mem_rsp),
    .retire_o(retire), .halt_o(halt)
  );

  core_monitor #(.RESET_PC(RESET_PC), .MEM_WORDS(MEM_WORDS)) monitor_i (
    .clk(clk), .rst(rst),
    .mem_req_i(mem_req), .mem_rsp_i(mem_rsp),
    .retire_i(retire), .halt_i(halt), .mem_init_i(mem),
    .errors_o(mon_errors), .retired_o(retired), .model_halted_o(model_halted)
  );

  function automatic int unsigned rnd(input int unsigned n);
    return {$random(seed)} % n;
  endfunction

  // Small pool of words in the data region so loads hit earlier stores
  function automatic logic [11:0] data_offset();
    return 12'(12'h800 + 4 * rnd(16));
  endfunction

  task automatic build_program();
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [20:0] off;
    int          kind, span;
    for (int i = 0; i < CODE_WORDS - 1; i++) begin
      rd   = 5'(rnd(16));
      rs1  = 5'(rnd(16));
      rs2  = 5'(rnd(16));
      f3   = 3'(rnd(8));
      imm  = 12'(rnd(4096));
      span = 1 + int'(rnd(4));
      if (i + span > CODE_WORDS - 1) begin
        span = CODE_WORDS - 1 - i;
      end
      off  = 21'(span * 4);
      kind = int'(rnd(16));
      case (kind)
        0: mem[i] = {20'(rnd(1 << 20)), rd, OP_LUI};
        1: mem[i] = {20'(rnd(1 << 20)), rd, OP_AUIPC};
        2, 3, 4: begin
          // Shifts carry only shamt and the arithmetic bit
          if (f3 == 3'd1 || f3 == 3'd5) begin
            imm = {1'b0, f3[2] & imm[10], 5'b0, imm[4:0]};
          end
          mem[i] = {imm, rs1, f3, rd, OP_IMM};
        end
        5, 6, 7: begin
          mem[i] = {1'b0, (f3 == 3'd0 || f3 == 3'd5) & imm[0], 5'b0,
                    rs2, rs1, f3, rd, OP_OP};
        end
        8, 9: begin
          if (f3 == 3'd2 || f3 == 3'd3) begin
            f3 = f3 + 3'd2;
          end
          mem[i] = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
        end
        10: mem[i] = {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
        11: begin
          // Absolute forward target, bit 0 set at random
          imm    = 12'((i + span) * 4) | 12'(imm[0]);
          mem[i] = {imm, 5'd0, 3'd0, rd, OP_JALR};
        end
        12, 13: mem[i] = {data_offset(), 5'd0, 3'b010, rd, OP_LOAD};
        default: begin
          imm    = data_offset();
          mem[i] = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], OP_STORE};
        end
      endcase
    end
    // EBREAK
    mem[CODE_WORDS - 1] = 32'h0010_0073;
  endtask

  task automatic answer_request();
    logic [9:0] idx;
    idx = mem_req.addr[11:2];
    if (mem_req.we) begin
      mem[idx] = mem_req.wdata;
    end
    mem_rsp = '{ack: 1'b1, rdata: mem[idx]};
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Memory image and responder with 0 to 3 cycles of delay
  initial begin
    seed    = 32'hf97efc98;
    mem_rsp = '0;
    busy    = 1'b0;
    delay   = 0;
    for (int k = 0; k < MEM_WORDS; k++) begin
      mem[k] = $random(seed);
    end
    build_program();
    forever begin
      @(negedge clk);
      if (mem_rsp.ack) begin
        mem_rsp.ack = 1'b0;
      end else if (mem_req.req) begin
        if (!busy) begin
          busy  = 1'b1;
          delay = int'(rnd(4));
        end
        if (delay == 0) begin
          answer_request();
          busy = 1'b0;
        end else begin
          delay--;
        end
      end
    end
  end

  initial begin
    rst       = 1'b1;
    tb_errors = 0;
    repeat (4) @(negedge clk);
    rst    = 1'b0;
    cycles = 0;
    while (!halt && cycles < HALT_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!halt) begin
      tb_errors++;
      $display("timeout: halt_o did not rise within %0d cycles", HALT_TIMEOUT);
    end else begin
      // Port must stay idle after halt
      for (int k = 0; k < IDLE_CYCLES; k++) begin
        @(negedge clk);
      end
      if (!model_halted) begin
        tb_errors++;
        $display("halt_o rose but the model never reached EBREAK");
      end
    end
    $display("errors: monitor %0d, testbench %0d (retired %0d)",
             mon_errors, tb_errors, retired);
    if (mon_errors == 0 && tb_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* sim/core_monitor.sv */
`timescale 1ns/1ps

module core_monitor import core_pkg::*; #(
  parameter logic [31:0] RESET_PC  = 32'h0,
  parameter int          MEM_WORDS = 1024
) (
  input  logic        clk,
  input  logic        rst,
  input  mem_req_t    mem_req_i,
  input  mem_rsp_t    mem_rsp_i,
  input  retire_t     retire_i,
  input  logic        halt_i,
  input  logic [31:0] mem_init_i [MEM_WORDS],
  output int          errors_o,
  output int          retired_o,
  output logic        model_halted_o
);
  localparam int AW = $clog2(MEM_WORDS);

  logic [31:0] mem_m [MEM_WORDS];
  logic [31:0] regs_m [32];
  logic [31:0] pc_m;
  logic        halted_m;
  int          errors;
  int          retired;
  // Last store seen on the memory port
  logic        wr_seen;
  logic [31:0] wr_addr;
  logic [31:0] wr_data;
  mem_req_t    prev_req;
  logic        prev_ack;
  logic        prev_valid;

  assign errors_o       = errors;
  assign retired_o      = retired;
  assign model_halted_o = halted_m;

  function automatic logic [31:0] sext(input logic [31:0] v, input int bits);
    return $signed(v << (32 - bits)) >>> (32 - bits);
  endfunction

  function automatic logic [31:0] alu(input logic [2:0] f3, input logic alt,
                                      input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: r = (a < b) ? 32'd1 : 32'd0;
      3'd4: r = a ^ b;
      3'd5: begin
        if (alt) begin
          r = $signed(a) >>> b[4:0];
        end else begin
          r = a >> b[4:0];
        end
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    logic t;
    case (f3)
      3'd0: t = a == b;
      3'd1: t = a != b;
      3'd4: t = $signed(a) < $signed(b);
      3'd5: t = $signed(a) >= $signed(b);
      3'd6: t = a < b;
      3'd7: t = a >= b;
      default: t = 1'b0;
    endcase
    return t;
  endfunction

  task automatic report(input string msg);
    $display("%0t: %s", $time, msg);
    errors++;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_store(input logic [31:0] addr, input logic [31:0] data);
    if (!wr_seen) begin
      report("store retired without a write on the memory port");
    end else begin
      check_value("mem_req.addr", wr_addr, addr);
      check_value("mem_req.wdata", wr_data, data);
    end
    wr_seen = 1'b0;
  endtask

  task automatic step_model(input retire_t r);
    inst_u       ins;
    logic [31:0] a, b, res, npc, addr;
    logic        wr, alt;
    ins  = mem_m[pc_m[AW+1:2]];
    a    = regs_m[ins.r.rs1];
    b    = regs_m[ins.r.rs2];
    res  = 32'h0;
    npc  = pc_m + 32'd4;
    wr   = 1'b1;
    alt  = ins.r.funct7[5] && (ins.r.opcode == OP_OP || ins.r.funct3 == 3'd5);
    case (ins.r.opcode)
      OP_LUI:   res = {ins.u.imm31_12, 12'h0};
      OP_AUIPC: res = pc_m + {ins.u.imm31_12, 12'h0};
      OP_JAL: begin
        res = pc_m + 32'd4;
        npc = pc_m + sext({11'h0, ins.j.imm20, ins.j.imm19_12, ins.j.imm11,
                           ins.j.imm10_1, 1'b0}, 21);
      end
      OP_JALR: begin
        res = pc_m + 32'd4;
        npc = (a + sext({20'h0, ins.i.imm}, 12)) & ~32'd1;
      end
      OP_BRANCH: begin
        wr = 1'b0;
        if (branch_taken(ins.b.funct3, a, b)) begin
          npc = pc_m + sext({19'h0, ins.b.imm12, ins.b.imm11, ins.b.imm10_5,
                             ins.b.imm4_1, 1'b0}, 13);
        end
      end
      OP_LOAD: begin
        addr = a + sext({20'h0, ins.i.imm}, 12);
        res  = mem_m[addr[AW+1:2]];
      end
      OP_STORE: begin
        wr   = 1'b0;
        addr = a + sext({20'h0, ins.s.imm_hi, ins.s.imm_lo}, 12);
        mem_m[addr[AW+1:2]] = b;
        check_store(addr, b);
      end
      OP_IMM: res = alu(ins.r.funct3, alt, a, sext({20'h0, ins.i.imm}, 12));
      OP_OP:  res = alu(ins.r.funct3, alt, a, b);
      default: begin
        // Only EBREAK reaches here
        wr       = 1'b0;
        halted_m = 1'b1;
        if (!halt_i) begin
          report("halt_o did not rise with the EBREAK retirement");
        end
      end
    endcase
    if (ins.r.opcode != OP_STORE && wr_seen) begin
      report("memory write seen for an instruction that is not a store");
      wr_seen = 1'b0;
    end
    if (!halted_m && halt_i) begin
      report("halt_o is set before EBREAK retired");
    end
    check_value("retire.pc", r.pc, pc_m);
    check_value("retire.inst", r.inst, ins);
    check_value("retire.we", 32'(r.we), 32'(wr));
    if (wr) begin
      check_value("retire.rd", 32'(r.rd), 32'(ins.r.rd));
      check_value("retire.wdata", r.wdata, res);
      if (ins.r.rd != 5'd0) begin
        regs_m[ins.r.rd] = res;
      end
    end
    pc_m = npc;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < MEM_WORDS; k++) begin
        mem_m[k] = mem_init_i[k];
      end
      for (int k = 0; k < 32; k++) begin
        regs_m[k] = 32'h0;
      end
      pc_m       = RESET_PC;
      halted_m   = 1'b0;
      errors     = 0;
      retired    = 0;
      wr_seen    = 1'b0;
      prev_req   = '0;
      prev_ack   = 1'b0;
      prev_valid = 1'b0;
    end else begin
      if (retire_i.valid) begin
        retired++;
        if (halted_m) begin
          report("instruction retired after EBREAK");
        end else begin
          step_model(retire_i);
        end
      end
      if (mem_req_i.req && mem_rsp_i.ack && mem_req_i.we) begin
        wr_seen = 1'b1;
        wr_addr = mem_req_i.addr;
        wr_data = mem_req_i.wdata;
      end
      if (prev_req.req && !prev_ack && mem_req_i != prev_req) begin
        report("memory request changed before its ack");
      end
      if (prev_valid && retire_i.valid) begin
        report("retire valid held for more than one cycle");
      end
      if (halt_i && mem_req_i.req) begin
        report("memory request issued after halt");
      end
      prev_req   = mem_req_i;
      prev_ack   = mem_rsp_i.ack;
      prev_valid = retire_i.valid;
    end
  end

endmodule

/* sim/core_checker.sv */
`timescale 1ns/1ps

module core_checker import core_pkg::*; (
  input logic     clk,
  input logic     rst,
  input mem_req_t mem_req_i,
  input mem_rsp_t mem_rsp_i,
  input retire_t  retire_i,
  input logic     halt_i
);

  // A pending request keeps every field until its ack
  req_stable: assert property (@(posedge clk) disable iff (rst)
    mem_req_i.req && !mem_rsp_i.ack |=> $stable(mem_req_i))
    else $error("memory request changed before its ack");

  retire_pulse: assert property (@(posedge clk) disable iff (rst)
    retire_i.valid |=> !retire_i.valid)
    else $error("retire valid held for more than one cycle");

  quiet_after_halt: assert property (@(posedge clk) disable iff (rst)
    halt_i |-> !mem_req_i.req)
    else $error("memory request issued after halt");

endmodule

bind core_top core_checker core_checker_i (
  .clk(clk), .rst(rst),
  .mem_req_i(mem_req_o), .mem_rsp_i(mem_rsp_i),
  .retire_i(retire_o), .halt_i(halt_o)
);

/* logic/core_top.sv */
`timescale 1ns/1ps

module core_top import core_pkg::*; #(
  parameter logic [31:0] RESET_PC = 32'h0,
  parameter int          NUM_REGS = 32
) (
  input  logic     clk,
  input  logic     rst,
  output mem_req_t mem_req_o,
  input  mem_rsp_t mem_rsp_i,
  output retire_t  retire_o,
  output logic     halt_o
);
  mem_req_t    ifu_req, lsu_req;
  mem_rsp_t    ifu_rsp, lsu_rsp;
  inst_u       ifu_inst;
  logic [31:0] ifu_pc;
  logic        ifu_valid, idu_ready;
  logic [4:0]  rs1_addr, rs2_addr;
  logic [31:0] rs1_data, rs2_data;
  logic        idu_valid, exu_ready;
  ctrl_t       ctrl;
  logic        lsu_start, lsu_we, lsu_done;
  logic [31:0] lsu_addr, lsu_wdata, lsu_rdata;
  logic        rf_we;
  logic [4:0]  rf_waddr;
  logic [31:0] rf_wdata;
  logic        exu_done;
  logic [31:0] next_pc;

  regfile #(.NUM_REGS(NUM_REGS)) regfile_i (
    .clk(clk), .rst(rst),
    .raddr1_i(rs1_addr), .raddr2_i(rs2_addr),
    .rdata1_o(rs1_data), .rdata2_o(rs2_data),
    .we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata)
  );

  ifu #(.RESET_PC(RESET_PC)) ifu_i (
    .clk(clk), .rst(rst),
    .exu_done_i(exu_done), .next_pc_i(next_pc), .halt_i(halt_o),
    .mem_req_o(ifu_req), .mem_rsp_i(ifu_rsp),
    .valid_o(ifu_valid), .ready_i(idu_ready), .inst_o(ifu_inst), .pc_o(ifu_pc)
  );

  idu #(.NUM_REGS(NUM_REGS)) idu_i (
    .clk(clk), .rst(rst),
    .valid_i(ifu_valid), .ready_o(idu_ready), .inst_i(ifu_inst), .pc_i(ifu_pc),
    .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
    .valid_o(idu_valid), .ready_i(exu_ready), .ctrl_o(ctrl)
  );

  exu exu_i (
    .clk(clk), .rst(rst),
    .valid_i(idu_valid), .ready_o(exu_ready), .ctrl_i(ctrl),
    .lsu_start_o(lsu_start), .lsu_we_o(lsu_we),
    .lsu_addr_o(lsu_addr), .lsu_wdata_o(lsu_wdata),
    .lsu_done_i(lsu_done), .lsu_rdata_i(lsu_rdata),
    .rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
    .done_o(exu_done), .next_pc_o(next_pc), .retire_o(retire_o), .halt_o(halt_o)
  );

  lsu lsu_i (
    .clk(clk), .rst(rst),
    .start_i(lsu_start), .we_i(lsu_we), .addr_i(lsu_addr), .wdata_i(lsu_wdata),
    .mem_req_o(lsu_req), .mem_rsp_i(lsu_rsp),
    .done_o(lsu_done), .rdata_o(lsu_rdata)
  );

  mem_arbiter mem_arbiter_i (
    .clk(clk), .rst(rst),
    .ifu_req_i(ifu_req), .ifu_rsp_o(ifu_rsp),
    .lsu_req_i(lsu_req), .lsu_rsp_o(lsu_rsp),
    .mem_req_o(mem_req_o), .mem_rsp_i(mem_rsp_i)
  );

endmodule

/* logic/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter import core_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  mem_req_t ifu_req_i,
  output mem_rsp_t ifu_rsp_o,
  input  mem_req_t lsu_req_i,
  output mem_rsp_t lsu_rsp_o,
  output mem_req_t mem_req_o,
  input  mem_rsp_t mem_rsp_i
);
  typedef enum logic [1:0] {G_IDLE, G_FETCH, G_LSU} grant_e;

  grant_e grant_q;
  logic   sel_ifu;
  logic   sel_lsu;

  // LSU wins a tie in idle
  assign sel_lsu = grant_q == G_LSU || (grant_q == G_IDLE && lsu_req_i.req);
  assign sel_ifu = grant_q == G_FETCH ||
                   (grant_q == G_IDLE && !lsu_req_i.req && ifu_req_i.req);

  assign mem_req_o = sel_lsu ? lsu_req_i : (sel_ifu ? ifu_req_i : '0);

  assign ifu_rsp_o = '{ack: sel_ifu && mem_rsp_i.ack, rdata: mem_rsp_i.rdata};
  assign lsu_rsp_o = '{ack: sel_lsu && mem_rsp_i.ack, rdata: mem_rsp_i.rdata};

  always_ff @(posedge clk) begin
    if (rst) begin
      grant_q <= G_IDLE;
    end else if (mem_rsp_i.ack) begin
      grant_q <= G_IDLE;
    end else if (grant_q == G_IDLE) begin
      if (sel_lsu) begin
        grant_q <= G_LSU;
      end else if (sel_ifu) begin
        grant_q <= G_FETCH;
      end
    end
  end

endmodule

/* logic/lsu.sv */
`timescale 1ns/1ps

module lsu import core_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        start_i,
  input  logic        we_i,
  input  logic [31:0] addr_i,
  input  logic [31:0] wdata_i,
  output mem_req_t    mem_req_o,
  input  mem_rsp_t    mem_rsp_i,
  output logic        done_o,
  output logic [31:0] rdata_o
);
  logic        req_q;
  logic        done_q;
  logic        we_q;
  logic [31:0] addr_q;
  logic [31:0] wdata_q;
  logic [31:0] rdata_q;

  assign mem_req_o = '{req: req_q, we: we_q, addr: addr_q, wdata: wdata_q};
  assign done_o    = done_q;
  assign rdata_o   = rdata_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      req_q  <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= req_q && mem_rsp_i.ack;
      if (req_q && mem_rsp_i.ack) begin
        req_q <= 1'b0;
      end else if (start_i) begin
        req_q <= 1'b1;
      end
    end
  end

  // Only one access in flight, so start never lands while busy
  always_ff @(posedge clk) begin
    if (start_i && !req_q) begin
      we_q    <= we_i;
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
    end
    if (req_q && mem_rsp_i.ack) begin
      rdata_q <= mem_rsp_i.rdata;
    end
  end

endmodule

/* logic/exu.sv */
`timescale 1ns/1ps

module exu import core_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        valid_i,
  output logic        ready_o,
  input  ctrl_t       ctrl_i,
  output logic        lsu_start_o,
  output logic        lsu_we_o,
  output logic [31:0] lsu_addr_o,
  output logic [31:0] lsu_wdata_o,
  input  logic        lsu_done_i,
  input  logic [31:0] lsu_rdata_i,
  output logic        rf_we_o,
  output logic [4:0]  rf_waddr_o,
  output logic [31:0] rf_wdata_o,
  output logic        done_o,
  output logic [31:0] next_pc_o,
  output retire_t     retire_o,
  output logic        halt_o
);
  typedef enum logic {S_IDLE, S_WAIT} state_e;

  state_e      state_q;
  ctrl_t       ctrl_q;
  ctrl_t       cur;
  logic        accept, is_mem, finish, taken;
  logic [31:0] op_a, op_b, alu_res, pc_plus4, wb_data, next_pc;
  logic        done_q, halt_q;
  logic [31:0] next_pc_q;
  retire_t     retire_q;

  assign ready_o = state_q == S_IDLE && !halt_q;
  assign accept  = valid_i && ready_o;
  // Held copy while the LSU works
  assign cur     = (state_q == S_WAIT) ? ctrl_q : ctrl_i;
  assign is_mem  = cur.is_load || cur.is_store;
  assign finish  = (accept && !is_mem) || (state_q == S_WAIT && lsu_done_i);

  assign op_a     = cur.is_auipc ? cur.pc : cur.rs1_val;
  assign op_b     = cur.use_imm ? cur.imm : cur.rs2_val;
  assign pc_plus4 = cur.pc + 32'd4;

  always_comb begin
    case (cur.alu_op)
      ALU_ADD:    alu_res = op_a + op_b;
      ALU_SUB:    alu_res = op_a - op_b;
      ALU_SLL:    alu_res = op_a << op_b[4:0];
      ALU_SLT:    alu_res = {31'h0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   alu_res = {31'h0, op_a < op_b};
      ALU_XOR:    alu_res = op_a ^ op_b;
      ALU_SRL:    alu_res = op_a >> op_b[4:0];
      ALU_SRA:    alu_res = $signed(op_a) >>> op_b[4:0];
      ALU_OR:     alu_res = op_a | op_b;
      ALU_AND:    alu_res = op_a & op_b;
      ALU_PASS_B: alu_res = op_b;
      default:    alu_res = op_b;
    endcase
  end

  always_comb begin
    case (cur.funct3)
      3'b000:  taken = cur.rs1_val == cur.rs2_val;
      3'b001:  taken = cur.rs1_val != cur.rs2_val;
      3'b100:  taken = $signed(cur.rs1_val) < $signed(cur.rs2_val);
      3'b101:  taken = $signed(cur.rs1_val) >= $signed(cur.rs2_val);
      3'b110:  taken = cur.rs1_val < cur.rs2_val;
      3'b111:  taken = cur.rs1_val >= cur.rs2_val;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    if (cur.is_jal || (cur.is_branch && taken)) begin
      next_pc = cur.pc + cur.imm;
    end else if (cur.is_jalr) begin
      next_pc = alu_res & ~32'd1;
    end else begin
      next_pc = pc_plus4;
    end
  end

  assign wb_data = cur.is_load ? lsu_rdata_i :
                   (cur.is_jal || cur.is_jalr) ? pc_plus4 : alu_res;

  assign lsu_start_o = accept && is_mem;
  assign lsu_we_o    = cur.is_store;
  assign lsu_addr_o  = alu_res;
  assign lsu_wdata_o = cur.rs2_val;

  // Write lands on the same edge that raises retire
  assign rf_we_o    = finish && cur.reg_we;
  assign rf_waddr_o = cur.rd;
  assign rf_wdata_o = wb_data;

  assign done_o    = done_q;
  assign next_pc_o = next_pc_q;
  assign retire_o  = retire_q;
  assign halt_o    = halt_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q  <= S_IDLE;
      done_q   <= 1'b0;
      halt_q   <= 1'b0;
      retire_q <= '0;
    end else begin
      done_q   <= finish;
      retire_q <= '{valid: finish, pc: cur.pc, inst: cur.inst, rd: cur.rd,
                    we: cur.reg_we, wdata: wb_data};
      if (finish && cur.is_ebreak) begin
        halt_q <= 1'b1;
      end
      if (accept && is_mem) begin
        state_q <= S_WAIT;
      end else if (state_q == S_WAIT && lsu_done_i) begin
        state_q <= S_IDLE;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      ctrl_q <= ctrl_i;
    end
    if (finish) begin
      next_pc_q <= next_pc;
    end
  end

endmodule

/* logic/idu.sv */
`timescale 1ns/1ps

module idu import core_pkg::*; #(
  parameter int NUM_REGS = 32
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        valid_i,
  output logic        ready_o,
  input  inst_u       inst_i,
  input  logic [31:0] pc_i,
  output logic [4:0]  rs1_addr_o,
  output logic [4:0]  rs2_addr_o,
  input  logic [31:0] rs1_data_i,
  input  logic [31:0] rs2_data_i,
  output logic        valid_o,
  input  logic        ready_i,
  output ctrl_t       ctrl_o
);
  localparam int AW = $clog2(NUM_REGS);

  logic    valid_q;
  ctrl_t   ctrl_q;
  ctrl_t   dec;
  alu_op_e f3_op;

  assign rs1_addr_o = 5'(inst_i.r.rs1[AW-1:0]);
  assign rs2_addr_o = 5'(inst_i.r.rs2[AW-1:0]);
  assign ready_o    = !valid_q;
  assign valid_o    = valid_q;
  assign ctrl_o     = ctrl_q;

  // funct3 map shared by OP and OP-IMM; bit 30 picks SUB and SRA
  always_comb begin
    case (inst_i.r.funct3)
      3'b000:  f3_op = (inst_i.r.opcode == OP_OP && inst_i.r.funct7[5]) ? ALU_SUB : ALU_ADD;
      3'b001:  f3_op = ALU_SLL;
      3'b010:  f3_op = ALU_SLT;
      3'b011:  f3_op = ALU_SLTU;
      3'b100:  f3_op = ALU_XOR;
      3'b101:  f3_op = inst_i.r.funct7[5] ? ALU_SRA : ALU_SRL;
      3'b110:  f3_op = ALU_OR;
      default: f3_op = ALU_AND;
    endcase
  end

  always_comb begin
    dec         = '0;
    dec.pc      = pc_i;
    dec.inst    = inst_i;
    dec.rs1_val = rs1_data_i;
    dec.rs2_val = rs2_data_i;
    dec.rd      = 5'(inst_i.r.rd[AW-1:0]);
    dec.funct3  = inst_i.r.funct3;
    dec.alu_op  = ALU_ADD;
    dec.imm     = {{20{inst_i.i.imm[11]}}, inst_i.i.imm};
    case (inst_i.r.opcode)
      OP_LUI, OP_AUIPC: begin
        dec.imm      = {inst_i.u.imm31_12, 12'h0};
        dec.use_imm  = 1'b1;
        dec.reg_we   = 1'b1;
        dec.is_auipc = inst_i.u.opcode == OP_AUIPC;
        dec.alu_op   = dec.is_auipc ? ALU_ADD : ALU_PASS_B;
      end
      OP_JAL: begin
        dec.imm    = {{11{inst_i.j.imm20}}, inst_i.j.imm20, inst_i.j.imm19_12,
                      inst_i.j.imm11, inst_i.j.imm10_1, 1'b0};
        dec.reg_we = 1'b1;
        dec.is_jal = 1'b1;
      end
      OP_JALR: begin
        dec.use_imm = 1'b1;
        dec.reg_we  = 1'b1;
        dec.is_jalr = 1'b1;
      end
      OP_BRANCH: begin
        dec.imm       = {{19{inst_i.b.imm12}}, inst_i.b.imm12, inst_i.b.imm11,
                         inst_i.b.imm10_5, inst_i.b.imm4_1, 1'b0};
        dec.is_branch = 1'b1;
      end
      OP_LOAD: begin
        dec.use_imm = 1'b1;
        dec.reg_we  = 1'b1;
        dec.is_load = 1'b1;
      end
      OP_STORE: begin
        dec.imm      = {{20{inst_i.s.imm_hi[6]}}, inst_i.s.imm_hi, inst_i.s.imm_lo};
        dec.use_imm  = 1'b1;
        dec.is_store = 1'b1;
      end
      OP_IMM, OP_OP: begin
        dec.use_imm = inst_i.r.opcode == OP_IMM;
        dec.reg_we  = 1'b1;
        dec.alu_op  = f3_op;
      end
      OP_SYSTEM: dec.is_ebreak = inst_i.i.imm == 12'h001;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (valid_i && ready_o) begin
      valid_q <= 1'b1;
    end else if (ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i && ready_o) begin
      ctrl_q <= dec;
    end
  end

endmodule

/* logic/ifu.sv */
`timescale 1ns/1ps

module ifu import core_pkg::*; #(
  parameter logic [31:0] RESET_PC = 32'h0
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        exu_done_i,
  input  logic [31:0] next_pc_i,
  input  logic        halt_i,
  output mem_req_t    mem_req_o,
  input  mem_rsp_t    mem_rsp_i,
  output logic        valid_o,
  input  logic        ready_i,
  output inst_u       inst_o,
  output logic [31:0] pc_o
);
  logic [31:0] pc_q;
  logic        boot_q;
  logic        req_q;
  logic        valid_q;
  inst_u       inst_q;

  assign mem_req_o = '{req: req_q, we: 1'b0, addr: pc_q, wdata: 32'h0};
  assign valid_o   = valid_q;
  assign inst_o    = inst_q;
  assign pc_o      = pc_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q    <= RESET_PC;
      boot_q  <= 1'b1;
      req_q   <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      boot_q <= 1'b0;
      // First fetch right after reset
      if (boot_q) begin
        req_q <= 1'b1;
      end
      if (exu_done_i) begin
        pc_q  <= next_pc_i;
        req_q <= !halt_i;
      end
      if (req_q && mem_rsp_i.ack) begin
        req_q   <= 1'b0;
        valid_q <= 1'b1;
      end else if (valid_q && ready_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_q && mem_rsp_i.ack) begin
      inst_q <= mem_rsp_i.rdata;
    end
  end

endmodule

/* logic/regfile.sv */
`timescale 1ns/1ps

module regfile #(
  parameter int NUM_REGS = 32
) (
  input  logic        clk,
  input  logic        rst,
  input  logic [4:0]  raddr1_i,
  input  logic [4:0]  raddr2_i,
  output logic [31:0] rdata1_o,
  output logic [31:0] rdata2_o,
  input  logic        we_i,
  input  logic [4:0]  waddr_i,
  input  logic [31:0] wdata_i
);
  localparam int AW = $clog2(NUM_REGS);

  logic [31:0] regs [NUM_REGS];

  // x0 is never written, so it reads back as zero
  assign rdata1_o = regs[raddr1_i[AW-1:0]];
  assign rdata2_o = regs[raddr2_i[AW-1:0]];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < NUM_REGS; k++) begin
        regs[k] <= '0;
      end
    end else if (we_i && waddr_i[AW-1:0] != '0) begin
      regs[waddr_i[AW-1:0]] <= wdata_i;
    end
  end

endmodule

/* logic/core_pkg.sv */
package core_pkg;

  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_OP     = 7'b0110011,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  // Instruction formats, MSB first
  typedef struct packed {
    logic [6:0] funct7; logic [4:0] rs2; logic [4:0] rs1;
    logic [2:0] funct3; logic [4:0] rd;  opcode_e    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm; logic [4:0] rs1; logic [2:0] funct3;
    logic [4:0]  rd;  opcode_e    opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi; logic [4:0] rs2; logic [4:0] rs1;
    logic [2:0] funct3; logic [4:0] imm_lo; opcode_e opcode;
  } s_fmt_t;

  typedef struct packed {
    logic imm12; logic [5:0] imm10_5; logic [4:0] rs2; logic [4:0] rs1;
    logic [2:0] funct3; logic [3:0] imm4_1; logic imm11; opcode_e opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm31_12; logic [4:0] rd; opcode_e opcode;
  } u_fmt_t;

  typedef struct packed {
    logic imm20; logic [9:0] imm10_1; logic imm11; logic [7:0] imm19_12;
    logic [4:0] rd; opcode_e opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } inst_u;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] imm;
    logic [4:0]  rd;
    alu_op_e     alu_op;
    logic use_imm, reg_we, is_load, is_store, is_branch;
    logic is_jal, is_jalr, is_auipc, is_ebreak;
    logic [2:0]  funct3;
  } ctrl_t;

  typedef struct packed {
    logic        req;
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] inst;
    logic [4:0]  rd;
    logic        we;
    logic [31:0] wdata;
  } retire_t;

endpackage
